/* logic/fetch_pkg.sv */
// instruction fetch unit, shared definitions
// word and address widths, reset constants and
// the output stage state encoding

package fetch_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // data and address width
    localparam int XLEN = 32;

    // instruction word as read from memory
    typedef logic [XLEN-1:0] word_t;

    // byte address, also used for the pc
    typedef logic [XLEN-1:0] addr_t;

    //////////////////////////////
    // constants
    //////////////////////////////

    // first fetch after reset
    localparam addr_t START_ADDR = '0;

    // byte distance between sequential instructions
    localparam addr_t INSTR_STEP = addr_t'(4);

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    // output stage: waiting on new target or streaming
    typedef enum logic {
        OUT_REDIRECT,
        OUT_STREAM
    } out_state_e;

endpackage

/* logic/fetch_pc_gen.sv */
// fetch address generator
// picks the redirect target, holds or advances the fetch
// address and tracks which memory answers are still wanted

`timescale 1ns/1ps

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  enable_i,
    input  logic  jump_i,
    input  addr_t jump_target_i,
    input  logic  ctx_switch_i,
    input  addr_t ctx_switch_target_i,
    input  logic  busy_i,
    input  logic  full_i,
    output addr_t instruction_address_o,
    output logic  redirect_o,
    output addr_t redirect_addr_o,
    output logic  fetch_valid_o
);

    logic  redirect;
    logic  issue;
    logic  req_r;
    addr_t fetch_addr;

    //////////////////////////////
    // redirect select
    //////////////////////////////

    assign redirect = jump_i || ctx_switch_i;

    // context switch wins over a jump in the same cycle
    assign redirect_addr_o = ctx_switch_i ? ctx_switch_target_i : jump_target_i;
    assign redirect_o      = redirect;

    //////////////////////////////
    // request issue
    //////////////////////////////

    // answer of last cycle's request, dropped on redirect
    assign fetch_valid_o = req_r && !redirect;

    // memory free, no redirect, and room for the answer
    // room means decode takes a word now, or the buffer is
    // empty and nothing is landing in it this cycle
    assign issue = !busy_i && !redirect
                && (enable_i || (!full_i && !fetch_valid_o));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_addr <= START_ADDR;
            req_r      <= 1'b0;
        end else begin
            // a redirect cycle never issues
            req_r <= issue;
            if (redirect) begin
                fetch_addr <= redirect_addr_o;
            end else if (issue) begin
                fetch_addr <= fetch_addr + INSTR_STEP;
            end
        end
    end

    // held while busy_i or while no request goes out
    assign instruction_address_o = fetch_addr;

    //////////////////////////////
    // checks
    //////////////////////////////

    // first cycle out of reset: redirect inputs defined, target known if used
    assert property (@(posedge clk)
        $rose(reset_n) |-> !$isunknown({jump_i, ctx_switch_i})
                           && (!redirect || !$isunknown(redirect_addr_o)))
        else $error("redirect after reset release without a known target");

    // targets from execute must keep the fetch address on a word
    assert property (@(posedge clk) disable iff (!reset_n)
        instruction_address_o[1:0] == 2'b00)
        else $error("fetch address not word aligned: %h", instruction_address_o);

endmodule

/* logic/fetch_ibuf.sv */
// one-entry instruction buffer
// catches a fetched word while decode stalls and offers it
// ahead of the word coming from memory

`timescale 1ns/1ps

module fetch_ibuf
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  enable_i,
    input  logic  redirect_i,
    input  logic  fetch_valid_i,
    input  word_t instruction_data_i,
    output logic  full_o,
    output logic  avail_o,
    output word_t word_o
);

    logic  buf_valid;
    word_t buf_word;
    logic  accept;
    logic  store;

    // a word is on offer from the buffer or straight from memory
    assign avail_o = buf_valid || fetch_valid_i;
    assign word_o  = buf_valid ? buf_word : instruction_data_i;
    assign full_o  = buf_valid;

    // decode takes the offered word
    assign accept = enable_i && avail_o;

    // incoming word with nobody to take it
    assign store = fetch_valid_i && !accept && !redirect_i;

    //////////////////////////////
    // holding register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_valid <= 1'b0;
        end else if (redirect_i || accept) begin
            // old stream gone, or the held word went to decode
            buf_valid <= 1'b0;
        end else if (store) begin
            buf_valid <= 1'b1;
        end
    end

    // payload only, qualified by buf_valid
    always_ff @(posedge clk) begin
        if (store) begin
            buf_word <= instruction_data_i;
        end
    end

    // request gating in the address generator must keep this from overflowing
    assert property (@(posedge clk) disable iff (!reset_n)
        full_o && !accept |-> !fetch_valid_i)
        else $error("instruction buffer overflow, word arrived while full");

endmodule

/* logic/fetch_out.sv */
// fetch output stage
// registers the instruction, its pc and the valid flag for
// decode, and tracks when a redirect has been delivered

`timescale 1ns/1ps

module fetch_out
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  enable_i,
    input  logic  redirect_i,
    input  addr_t redirect_addr_i,
    input  logic  avail_i,
    input  word_t word_i,
    output addr_t pc_o,
    output word_t instruction_o,
    output logic  valid_o,
    output logic  jumping_o
);

    out_state_e state;
    addr_t      pending_pc;
    logic       accept;

    // word handed to decode at this edge
    // a redirect in the same cycle overrides it
    assign accept = enable_i && avail_i && !redirect_i;

    //////////////////////////////
    // jump tracking
    //////////////////////////////

    // reset behaves as a redirect to START_ADDR
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= OUT_REDIRECT;
        end else if (redirect_i) begin
            state <= OUT_REDIRECT;
        end else if (accept) begin
            state <= OUT_STREAM;
        end
    end

    // target kept until its first word shows up
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending_pc <= START_ADDR;
        end else if (redirect_i) begin
            pending_pc <= redirect_addr_i;
        end
    end

    assign jumping_o = (state == OUT_REDIRECT);

    //////////////////////////////
    // output registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (redirect_i) begin
            valid_o <= 1'b0;
        end else if (accept) begin
            valid_o <= 1'b1;
        end else if (enable_i) begin
            // decode moved on and nothing was there
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instruction_o <= NOP_INSTR;
            pc_o          <= START_ADDR;
        end else if (accept) begin
            instruction_o <= word_i;
            // first word after redirect carries the target
            pc_o <= (state == OUT_REDIRECT) ? pending_pc : pc_o + INSTR_STEP;
        end
    end

    // squashed stream must not leak to decode
    // nothing may be on offer in the cycle after a redirect
    assert property (@(posedge clk) disable iff (!reset_n)
        redirect_i |=> !valid_o && !avail_i)
        else $error("valid_o raised or stale word offered across a redirect");

endmodule

/* logic/fetch_top.sv */
// instruction fetch unit, top level
// address generator and buffer side by side, feeding the
// output stage toward decode

`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  enable_i,
    input  logic  jump_i,
    input  addr_t jump_target_i,
    input  logic  ctx_switch_i,
    input  addr_t ctx_switch_target_i,
    input  logic  busy_i,
    input  word_t instruction_data_i,
    output addr_t instruction_address_o,
    output addr_t pc_o,
    output word_t instruction_o,
    output logic  valid_o,
    output logic  jumping_o
);

    // between the three blocks
    logic  redirect;
    addr_t redirect_addr;
    logic  fetch_valid;
    logic  full;
    logic  avail;
    word_t word;

    //////////////////////////////
    // memory side
    //////////////////////////////

    fetch_pc_gen u_pc_gen (
        .clk                   (clk),
        .reset_n               (reset_n),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_i          (ctx_switch_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .busy_i                (busy_i),
        .full_i                (full),
        .instruction_address_o (instruction_address_o),
        .redirect_o            (redirect),
        .redirect_addr_o       (redirect_addr),
        .fetch_valid_o         (fetch_valid)
    );

    fetch_ibuf u_ibuf (
        .clk                (clk),
        .reset_n            (reset_n),
        .enable_i           (enable_i),
        .redirect_i         (redirect),
        .fetch_valid_i      (fetch_valid),
        .instruction_data_i (instruction_data_i),
        .full_o             (full),
        .avail_o            (avail),
        .word_o             (word)
    );

    //////////////////////////////
    // decode side
    //////////////////////////////

    fetch_out u_out (
        .clk             (clk),
        .reset_n         (reset_n),
        .enable_i        (enable_i),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .avail_i         (avail),
        .word_i          (word),
        .pc_o            (pc_o),
        .instruction_o   (instruction_o),
        .valid_o         (valid_o),
        .jumping_o       (jumping_o)
    );

endmodule

/* sim/fetch_tb_mem.sv */
// behavioral instruction memory for the fetch testbench
// answers one cycle after a request, the word read back
// is the bitwise inverse of its address

`timescale 1ns/1ps

module fetch_tb_mem (
    input  logic        clk,
    input  logic        busy_i,
    input  logic [31:0] addr_i,
    output logic [31:0] data_o
);

    //////////////////////////////
    // read port
    //////////////////////////////

    // request taken only while not busy
    // data held otherwise, fetch ignores it then
    always_ff @(posedge clk) begin
        if (!busy_i) begin
            data_o <= ~addr_i;
        end
    end

endmodule

/* sim/fetch_tb.sv */
// testbench for the instruction fetch unit
// random busy and enable from a stimulus table, redirects from
// the same table, scoreboard tracks the next expected pc

`timescale 1ns/1ps

module fetch_tb;

    localparam int          CLK_HALF     = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 50;
    localparam int          NUM_ROWS     = 12;
    localparam logic [31:0] START_PC     = 32'h0000_0000;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;
    localparam logic [31:0] PC_STEP      = 32'd4;

    // one stimulus row
    typedef struct packed {
        int unsigned cycles;
        int unsigned busy_pct;
        int unsigned en_pct;
        logic        jump;
        logic [31:0] jump_tgt;
        logic        ctx;
        logic [31:0] ctx_tgt;
    } row_t;

    logic        clk;
    logic        reset_n;
    logic        enable_i;
    logic        jump_i;
    logic [31:0] jump_target_i;
    logic        ctx_switch_i;
    logic [31:0] ctx_switch_target_i;
    logic        busy_i;
    logic [31:0] instruction_data_i;
    logic [31:0] instruction_address_o;
    logic [31:0] pc_o;
    logic [31:0] instruction_o;
    logic        valid_o;
    logic        jumping_o;

    row_t        rows [NUM_ROWS];
    int          seed = 32'h00b8_592c;
    int          errors = 0;
    int          timeouts = 0;
    int          deliveries = 0;

    // scoreboard state, updated at the falling edge
    logic        en_last;
    logic        redir_last;
    logic [31:0] tgt_last;
    logic [31:0] exp_pc;
    logic        exp_jump;
    logic [31:0] prev_pc;
    logic [31:0] prev_instr;
    logic        prev_valid;

    fetch_top UUT (
        .clk                   (clk),
        .reset_n               (reset_n),
        .enable_i              (enable_i),
        .jump_i                (jump_i),
        .jump_target_i         (jump_target_i),
        .ctx_switch_i          (ctx_switch_i),
        .ctx_switch_target_i   (ctx_switch_target_i),
        .busy_i                (busy_i),
        .instruction_data_i    (instruction_data_i),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_o),
        .instruction_o         (instruction_o),
        .valid_o               (valid_o),
        .jumping_o             (jumping_o)
    );

    fetch_tb_mem mem (
        .clk    (clk),
        .busy_i (busy_i),
        .addr_i (instruction_address_o),
        .data_o (instruction_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // cycles, busy %, enable %, jump, jump target, ctx switch, ctx target
    task load_table();
        rows[0]  = '{30, 0, 100, 1'b0, 32'h0, 1'b0, 32'h0};
        rows[1]  = '{40, 30, 70, 1'b0, 32'h0, 1'b0, 32'h0};
        rows[2]  = '{20, 20, 80, 1'b1, 32'h0000_0100, 1'b0, 32'h0};
        // long stall, then release
        rows[3]  = '{10, 0, 0, 1'b0, 32'h0, 1'b0, 32'h0};
        rows[4]  = '{30, 40, 50, 1'b0, 32'h0, 1'b0, 32'h0};
        rows[5]  = '{25, 25, 75, 1'b1, 32'h0000_0400, 1'b1, 32'h0000_8000};
        rows[6]  = '{40, 50, 50, 1'b0, 32'h0, 1'b0, 32'h0};
        rows[7]  = '{20, 10, 90, 1'b0, 32'h0, 1'b1, 32'h0001_0000};
        // jump while decode is stalled
        rows[8]  = '{8, 20, 0, 1'b1, 32'h0000_3000, 1'b0, 32'h0};
        rows[9]  = '{30, 60, 40, 1'b1, 32'h0000_2000, 1'b0, 32'h0};
        // stream wraps past the top of the address space
        rows[10] = '{20, 0, 100, 1'b1, 32'hffff_fff0, 1'b0, 32'h0};
        rows[11] = '{50, 35, 65, 1'b1, 32'h0000_0040, 1'b1, 32'h0000_0c00};
    endtask

    // one clock of stimulus, random busy and enable
    task automatic drive_cycle(input int unsigned busy_pct, input int unsigned en_pct,
                               input logic jmp, input logic [31:0] jt,
                               input logic ctx, input logic [31:0] ct);
        int unsigned r_busy;
        int unsigned r_en;
        @(posedge clk);
        r_busy = $random(seed);
        r_en   = $random(seed);
        busy_i              <= (r_busy % 100) < busy_pct;
        enable_i            <= (r_en % 100) < en_pct;
        jump_i              <= jmp;
        jump_target_i       <= jt;
        ctx_switch_i        <= ctx;
        ctx_switch_target_i <= ct;
    endtask

    // decode ready, memory still random, until one more delivery
    task automatic wait_delivery(input int unsigned busy_pct);
        int start;
        int n;
        start = deliveries;
        n     = 0;
        while (deliveries == start && n < WAIT_LIMIT) begin
            drive_cycle(busy_pct, 100, 1'b0, 32'h0, 1'b0, 32'h0);
            n++;
        end
        assert (deliveries != start) else begin
            timeouts++;
            $display("timeout: no instruction delivered within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task compare_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, got);
        end
    endtask

    //////////////////////////////
    // scoreboard
    //////////////////////////////

    // inputs seen here were applied at the edge just past
    always @(negedge clk) begin
        if (!reset_n) begin
            compare_word("instruction_o", instruction_o, NOP_WORD);
            compare_word("pc_o", pc_o, START_PC);
            compare_word("instruction_address_o", instruction_address_o, START_PC);
            compare_bit("valid_o", valid_o, 1'b0);
            compare_bit("jumping_o", jumping_o, 1'b1);
            exp_pc   = START_PC;
            exp_jump = 1'b1;
        end else begin
            if (redir_last) begin
                // ctx switch target wins
                exp_pc   = tgt_last;
                exp_jump = 1'b1;
                compare_bit("valid_o", valid_o, 1'b0);
                // fetch address jumps to the target at the redirect edge
                compare_word("instruction_address_o", instruction_address_o, tgt_last);
            end else if (en_last && valid_o) begin
                // enable high and valid after the edge means a new word
                compare_word("pc_o", pc_o, exp_pc);
                compare_word("instruction_o", instruction_o, ~exp_pc);
                exp_pc   = exp_pc + PC_STEP;
                exp_jump = 1'b0;
                deliveries++;
            end else if (!en_last) begin
                // decode stalled, outputs frozen
                compare_bit("valid_o", valid_o, prev_valid);
                compare_word("pc_o", pc_o, prev_pc);
                compare_word("instruction_o", instruction_o, prev_instr);
            end
            compare_bit("jumping_o", jumping_o, exp_jump);
        end
        en_last    = enable_i;
        redir_last = jump_i || ctx_switch_i;
        tgt_last   = ctx_switch_i ? ctx_switch_target_i : jump_target_i;
        prev_pc    = pc_o;
        prev_instr = instruction_o;
        prev_valid = valid_o;
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int i;
        int unsigned c;
        load_table();
        reset_n             <= 1'b0;
        enable_i            <= 1'b0;
        busy_i              <= 1'b0;
        jump_i              <= 1'b0;
        jump_target_i       <= 32'h0;
        ctx_switch_i        <= 1'b0;
        ctx_switch_target_i <= 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        for (i = 0; i < NUM_ROWS; i++) begin
            // one-cycle redirect pulse first
            if (rows[i].jump || rows[i].ctx) begin
                drive_cycle(rows[i].busy_pct, rows[i].en_pct, rows[i].jump,
                            rows[i].jump_tgt, rows[i].ctx, rows[i].ctx_tgt);
            end
            for (c = 0; c < rows[i].cycles; c++) begin
                drive_cycle(rows[i].busy_pct, rows[i].en_pct, 1'b0, 32'h0, 1'b0, 32'h0);
            end
            wait_delivery(rows[i].busy_pct);
        end

        drive_cycle(0, 0, 1'b0, 32'h0, 1'b0, 32'h0);
        @(negedge clk);
        $display("errors: %0d, timeouts: %0d, instructions delivered: %0d",
                 errors, timeouts, deliveries);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* src.f */
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_ibuf.sv
logic/fetch_out.sv
logic/fetch_top.sv
sim/fetch_tb_mem.sv
sim/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
    -f src.f \
    --top-module fetch_tb \
    -o fetch_sim

./obj_dir/fetch_sim 2>&1 | tee "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
